/* design/mboxPkg.sv */
// MBOX error slice definitions
package mboxPkg;

  localparam int ebusW    = 36;
  localparam int physAdrW = 22;
  localparam int diagSelW = 2;
  localparam int mbSelW   = 3;

  // Memory-buffer input source, same code drives the parity-bit mux
  localparam logic [mbSelW-1:0] mbSelCsh   = 3'd0;
  localparam logic [mbSelW-1:0] mbSelAr    = 3'd2;
  localparam logic [mbSelW-1:0] mbSelChBuf = 3'd3;
  localparam logic [mbSelW-1:0] mbSelMem   = 3'd4;
  localparam logic [mbSelW-1:0] mbSelCcw   = 3'd6;
  localparam logic [mbSelW-1:0] mbSelNone  = 3'd7;

  // ERA word, the upper 14 bits read as reference kind or page-fail state
  typedef union packed {
    struct packed {
      logic [1:0]                   wdSel;
      logic                         ccaRef;
      logic                         chanRef;
      logic [1:0]                   dataSource;
      logic                         memWrite;
      logic [ebusW-physAdrW-8:0]    pad;
      logic [physAdrW-1:0]          address;
    } era;
    struct packed {
      logic                         vmaUser;
      logic [4:0]                   pfHold;
      logic                         ptPublic;
      logic [ebusW-physAdrW-8:0]    pad;
      logic [physAdrW-1:0]          address;
    } pageFail;
  } eraWordU;

endpackage

/* design/coreBusyCtl.sv */
// Core busy and MB input select
`timescale 1ns/1ps

module coreBusyCtl (
  input  logic                       MBOX,
  input  logic                       arstN,
  input  logic                       memStart,
  input  logic                       memRdRq,
  input  logic                       chanCyc,
  input  logic                       chanToMem,
  input  logic                       nxmBusy,
  input  logic                       coreRdInProg,
  input  logic                       aRToMbSel,
  output logic                       coreBusy,
  output logic                       memBusy,
  output logic                       chanCoreBusy,
  output logic                       chanRead,
  output logic [mboxPkg::mbSelW-1:0] mbInSel
);

  logic                       chanDirToMem;
  logic                       chanWrMem;
  logic                       chanBufToMb;
  logic                       chanStatusToMb;
  logic [mboxPkg::mbSelW-1:0] mbInSelNext;

  assign memBusy   = memStart | nxmBusy | coreRdInProg;
  assign chanWrMem = chanCoreBusy & chanDirToMem;
  assign chanRead  = chanCoreBusy & ~chanDirToMem;

  // Status words are stored read-pause-write and buffer data as plain writes
  assign chanStatusToMb = chanWrMem & memRdRq;
  assign chanBufToMb    = chanWrMem & ~memRdRq;

  // EBOX store wins over channel traffic
  always_comb begin
    if (aRToMbSel)
      mbInSelNext = mboxPkg::mbSelAr;
    else if (chanBufToMb)
      mbInSelNext = mboxPkg::mbSelChBuf;
    else if (coreRdInProg)
      mbInSelNext = mboxPkg::mbSelMem;
    else if (chanStatusToMb)
      mbInSelNext = mboxPkg::mbSelCcw;
    else
      mbInSelNext = mboxPkg::mbSelNone;
  end

  always_ff @(posedge MBOX or negedge arstN) begin
    if (!arstN) begin
      coreBusy     <= 1'b0;
      chanCoreBusy <= 1'b0;
      chanDirToMem <= 1'b0;
      mbInSel      <= mboxPkg::mbSelNone;
    end else begin
      coreBusy     <= memStart | nxmBusy | chanCoreBusy;
      // Held until the start it launched goes away
      chanCoreBusy <= chanCyc | (chanCoreBusy & memStart);
      if (chanCyc)
        chanDirToMem <= chanToMem;
      mbInSel      <= mbInSelNext;
    end
  end

endmodule

/* design/nxmTimer.sv */
// Nonexistent memory timeout
`timescale 1ns/1ps

module nxmTimer #(
  parameter int nxmTimeout = 16
) (
  input  logic MBOX,
  input  logic arstN,
  input  logic memStart,
  input  logic acknPulse,
  input  logic memRdRq,
  input  logic nxmErrClr,
  output logic nxmAny,
  output logic nxmBusy,
  output logic nxmErr,
  output logic nxmDataVal
);

  localparam logic [7:0] cntLimit = 8'(nxmTimeout);

  logic [7:0] startCnt;
  logic       advance;
  logic       nxmAnyDly;
  // One-hot fake acknowledge steps
  logic [2:6] nxmT;

  assign advance    = memStart & ~acknPulse & ~nxmAny;
  assign nxmBusy    = |nxmT[2:5];
  assign nxmDataVal = nxmT[6] & memRdRq;

  always_ff @(posedge MBOX or negedge arstN) begin
    if (!arstN) begin
      startCnt <= '0;
      nxmAny   <= 1'b0;
    end else if (!memStart) begin
      startCnt <= '0;
      nxmAny   <= 1'b0;
    end else if (advance) begin
      // Flag goes up one edge after the count reaches the limit
      if (startCnt == cntLimit)
        nxmAny <= 1'b1;
      else
        startCnt <= startCnt + 8'd1;
    end
  end

  always_ff @(posedge MBOX or negedge arstN) begin
    if (!arstN) begin
      nxmAnyDly <= 1'b0;
      nxmT      <= '0;
      nxmErr    <= 1'b0;
    end else begin
      nxmAnyDly <= nxmAny;
      nxmT      <= {nxmAny & ~nxmAnyDly, nxmT[2:5]};
      if (nxmT[6])
        nxmErr <= 1'b1;
      else if (nxmErrClr)
        nxmErr <= 1'b0;
    end
  end

  assert property (@(posedge MBOX) disable iff (!arstN) $onehot0(nxmT))
    else $error("nxmTimer: T2-T6 sequence not one-hot");

  // A late acknowledge must not race the timeout
  assert property (@(posedge MBOX) disable iff (!arstN) $rose(nxmAny) |-> !acknPulse)
    else $error("nxmTimer: NXM raised on an acknowledged cycle");

endmodule

/* design/errorCapture.sv */
// Error flags and ERA
`timescale 1ns/1ps

module errorCapture (
  input  logic                         MBOX,
  input  logic                         arstN,
  input  logic                         memStart,
  input  logic                         acknPulse,
  input  logic                         memRdRq,
  input  logic                         memError,
  input  logic                         aChangeComing,
  input  logic                         mbParOdd,
  input  logic                         memAdrParErr,
  input  logic                         errClr,
  input  logic                         nxmErr,
  input  logic                         eraSel,
  input  logic                         chanRef,
  input  logic                         ccaRef,
  input  logic [1:0]                   mbWdSel,
  input  logic [1:0]                   dataSource,
  input  logic                         vmaUser,
  input  logic                         ptPublic,
  input  logic [4:0]                   pfHold,
  input  logic [mboxPkg::physAdrW-1:0] physAdr,
  output logic                         sbusErr,
  output logic                         mbParErr,
  output logic                         adrParErr,
  output logic                         holdEra,
  output mboxPkg::eraWordU             era
);

  logic memWrite;

  assign memWrite = ~memRdRq;
  assign holdEra  = ~memStart | sbusErr | mbParErr | adrParErr | nxmErr;

  always_ff @(posedge MBOX or negedge arstN) begin
    if (!arstN) begin
      sbusErr   <= 1'b0;
      mbParErr  <= 1'b0;
      adrParErr <= 1'b0;
    end else begin
      sbusErr   <= (memError & aChangeComing) | (sbusErr & ~errClr);
      // Parity is only checked on data the MB sends to memory
      mbParErr  <= (acknPulse & memWrite & ~mbParOdd) | (mbParErr & ~errClr);
      adrParErr <= memAdrParErr | (adrParErr & ~errClr);
    end
  end

  // ERA tracks each reference until something goes wrong
  always_ff @(posedge MBOX or negedge arstN) begin
    if (!arstN) begin
      era <= '0;
    end else if (!holdEra) begin
      if (eraSel) begin
        era.era.wdSel      <= mbWdSel;
        era.era.ccaRef     <= ccaRef;
        era.era.chanRef    <= chanRef;
        era.era.dataSource <= dataSource;
        era.era.memWrite   <= memWrite;
        era.era.pad        <= '0;
      end else begin
        era.pageFail.vmaUser  <= vmaUser;
        era.pageFail.pfHold   <= pfHold;
        era.pageFail.ptPublic <= ptPublic;
        era.pageFail.pad      <= '0;
      end
      era.era.address <= physAdr;
    end
  end

endmodule

/* design/chanParityBuf.sv */
// Channel buffer parity
`timescale 1ns/1ps

module chanParityBuf #(
  parameter int chBufAdrW = 7
) (
  input  logic                       MBOX,
  input  logic                       arstN,
  input  logic                       chBufWr,
  input  logic                       chBufMbSel,
  input  logic                       dataReverse,
  input  logic                       mbParLeft,
  input  logic                       mbParRight,
  input  logic                       cbusParLeft,
  input  logic                       cbusParRight,
  input  logic                       arParOdd,
  input  logic                       memParIn,
  input  logic                       cshParBit,
  input  logic                       ccwParBit,
  input  logic [chBufAdrW-1:0]       chBufAdr,
  input  logic [mboxPkg::mbSelW-1:0] mbInSel,
  output logic [1:0]                 chBufPar,
  output logic                       mbParBitIn
);

  // Bit 1 is the left half word, bit 0 the right
  logic [1:0] parRam [0:2**chBufAdrW-1];
  logic [1:0] wrPar;

  always_comb begin
    if (chBufMbSel)
      wrPar = {mbParLeft, mbParRight};
    else if (dataReverse)
      wrPar = {cbusParRight, cbusParLeft};
    else
      wrPar = {cbusParLeft, cbusParRight};
  end

  always_ff @(posedge MBOX) begin
    if (chBufWr)
      parRam[chBufAdr] <= wrPar;
  end

  always_ff @(posedge MBOX or negedge arstN) begin
    if (!arstN)
      chBufPar <= '0;
    else
      chBufPar <= parRam[chBufAdr];
  end

  always_comb begin
    case (mbInSel)
      mboxPkg::mbSelCsh:   mbParBitIn = cshParBit;
      mboxPkg::mbSelAr:    mbParBitIn = arParOdd;
      mboxPkg::mbSelChBuf: mbParBitIn = ^chBufPar;
      mboxPkg::mbSelMem:   mbParBitIn = memParIn;
      mboxPkg::mbSelCcw:   mbParBitIn = ccwParBit;
      default:             mbParBitIn = 1'b0;
    endcase
  end

endmodule

/* design/diagReadMux.sv */
// Diagnostic E-bus readout
`timescale 1ns/1ps

module diagReadMux (
  input  logic                         diagRead,
  input  logic [mboxPkg::diagSelW-1:0] diagSel,
  input  mboxPkg::eraWordU             era,
  input  logic                         coreBusy,
  input  logic                         memBusy,
  input  logic                         nxmAny,
  input  logic                         nxmErr,
  input  logic                         sbusErr,
  input  logic                         mbParErr,
  input  logic                         adrParErr,
  input  logic                         chanRead,
  input  logic [mboxPkg::mbSelW-1:0]   mbInSel,
  output logic                         driving,
  output logic [0:mboxPkg::ebusW-1]    ebusData
);

  // ERA in E-bus bit order, bit 0 is the MSB
  logic [0:mboxPkg::ebusW-1] eraBits;
  logic [0:3]                statNib;

  assign eraBits = era;

  always_comb begin
    case (diagSel)
      2'd0:    statNib = {coreBusy, adrParErr, memBusy, nxmAny};
      2'd1:    statNib = {nxmErr, sbusErr, mbParErr, chanRead};
      2'd2:    statNib = {mbInSel, 1'b0};
      default: statNib = 4'b0000;
    endcase
  end

  assign driving  = diagRead;
  // Status nibble sits in bits 9-12, bit 13 unused
  assign ebusData = driving ?
                    {eraBits[0:8], statNib, 1'b0, eraBits[14:mboxPkg::ebusW-1]} :
                    '0;

endmodule

/* design/mboxErrTop.sv */
// MBOX error and status slice
`timescale 1ns/1ps

module mboxErrTop #(
  parameter int nxmTimeout = 16,
  parameter int chBufAdrW  = 7
) (
  input  logic                         MBOX,
  input  logic                         arstN,
  input  logic                         memStart,
  input  logic                         memRdRq,
  input  logic                         acknPulse,
  input  logic [mboxPkg::physAdrW-1:0] physAdr,
  input  logic                         chanCyc,
  input  logic                         chanToMem,
  input  logic                         coreRdInProg,
  input  logic                         aRToMbSel,
  input  logic                         nxmErrClr,
  input  logic                         memError,
  input  logic                         aChangeComing,
  input  logic                         mbParOdd,
  input  logic                         memAdrParErr,
  input  logic                         errClr,
  input  logic                         eraSel,
  input  logic                         ccaRef,
  input  logic [1:0]                   mbWdSel,
  input  logic [1:0]                   dataSource,
  input  logic                         vmaUser,
  input  logic                         ptPublic,
  input  logic [4:0]                   pfHold,
  input  logic                         chBufWr,
  input  logic [chBufAdrW-1:0]         chBufAdr,
  input  logic                         chBufMbSel,
  input  logic                         dataReverse,
  input  logic                         mbParLeft,
  input  logic                         mbParRight,
  input  logic                         cbusParLeft,
  input  logic                         cbusParRight,
  input  logic                         arParOdd,
  input  logic                         memParIn,
  input  logic                         cshParBit,
  input  logic                         ccwParBit,
  input  logic                         diagRead,
  input  logic [mboxPkg::diagSelW-1:0] diagSel,
  output logic                         memBusy,
  output logic                         coreBusy,
  output logic                         chanRead,
  output logic                         nxmDataVal,
  output logic                         holdEra,
  output logic [1:0]                   chBufPar,
  output logic                         mbParBitIn,
  output logic                         driving,
  output logic [0:mboxPkg::ebusW-1]    ebusData
);

  logic                       chanCoreBusy;
  logic [mboxPkg::mbSelW-1:0] mbInSel;
  logic                       nxmAny;
  logic                       nxmBusy;
  logic                       nxmErr;
  logic                       sbusErr;
  logic                       mbParErr;
  logic                       adrParErr;
  mboxPkg::eraWordU           era;

  coreBusyCtl coreBusyCtl (
    .MBOX         (MBOX),
    .arstN        (arstN),
    .memStart     (memStart),
    .memRdRq      (memRdRq),
    .chanCyc      (chanCyc),
    .chanToMem    (chanToMem),
    .nxmBusy      (nxmBusy),
    .coreRdInProg (coreRdInProg),
    .aRToMbSel    (aRToMbSel),
    .coreBusy     (coreBusy),
    .memBusy      (memBusy),
    .chanCoreBusy (chanCoreBusy),
    .chanRead     (chanRead),
    .mbInSel      (mbInSel)
  );

  nxmTimer #(
    .nxmTimeout (nxmTimeout)
  ) nxmTimer (
    .MBOX       (MBOX),
    .arstN      (arstN),
    .memStart   (memStart),
    .acknPulse  (acknPulse),
    .memRdRq    (memRdRq),
    .nxmErrClr  (nxmErrClr),
    .nxmAny     (nxmAny),
    .nxmBusy    (nxmBusy),
    .nxmErr     (nxmErr),
    .nxmDataVal (nxmDataVal)
  );

  // Channel reference kind comes from the channel busy state
  errorCapture errorCapture (
    .MBOX          (MBOX),
    .arstN         (arstN),
    .memStart      (memStart),
    .acknPulse     (acknPulse),
    .memRdRq       (memRdRq),
    .memError      (memError),
    .aChangeComing (aChangeComing),
    .mbParOdd      (mbParOdd),
    .memAdrParErr  (memAdrParErr),
    .errClr        (errClr),
    .nxmErr        (nxmErr),
    .eraSel        (eraSel),
    .chanRef       (chanCoreBusy),
    .ccaRef        (ccaRef),
    .mbWdSel       (mbWdSel),
    .dataSource    (dataSource),
    .vmaUser       (vmaUser),
    .ptPublic      (ptPublic),
    .pfHold        (pfHold),
    .physAdr       (physAdr),
    .sbusErr       (sbusErr),
    .mbParErr      (mbParErr),
    .adrParErr     (adrParErr),
    .holdEra       (holdEra),
    .era           (era)
  );

  chanParityBuf #(
    .chBufAdrW (chBufAdrW)
  ) chanParityBuf (
    .MBOX         (MBOX),
    .arstN        (arstN),
    .chBufWr      (chBufWr),
    .chBufMbSel   (chBufMbSel),
    .dataReverse  (dataReverse),
    .mbParLeft    (mbParLeft),
    .mbParRight   (mbParRight),
    .cbusParLeft  (cbusParLeft),
    .cbusParRight (cbusParRight),
    .arParOdd     (arParOdd),
    .memParIn     (memParIn),
    .cshParBit    (cshParBit),
    .ccwParBit    (ccwParBit),
    .chBufAdr     (chBufAdr),
    .mbInSel      (mbInSel),
    .chBufPar     (chBufPar),
    .mbParBitIn   (mbParBitIn)
  );

  diagReadMux diagReadMux (
    .diagRead  (diagRead),
    .diagSel   (diagSel),
    .era       (era),
    .coreBusy  (coreBusy),
    .memBusy   (memBusy),
    .nxmAny    (nxmAny),
    .nxmErr    (nxmErr),
    .sbusErr   (sbusErr),
    .mbParErr  (mbParErr),
    .adrParErr (adrParErr),
    .chanRead  (chanRead),
    .mbInSel   (mbInSel),
    .driving   (driving),
    .ebusData  (ebusData)
  );

endmodule

/* testbench/mboxErrTb.sv */
// MBOX error slice testbench
`timescale 1ns/1ps

module mboxErrTb;

  localparam int nxmTimeout = 8;
  localparam int chBufAdrW  = 7;
  localparam int adrW       = mboxPkg::physAdrW;
  localparam int waitLimit  = 40;

  logic                         MBOX;
  logic                         arstN;
  logic                         memStart, memRdRq, acknPulse;
  logic [adrW-1:0]              physAdr;
  logic                         chanCyc, chanToMem, coreRdInProg, aRToMbSel;
  logic                         nxmErrClr, memError, aChangeComing, mbParOdd;
  logic                         memAdrParErr, errClr, eraSel, ccaRef;
  logic [1:0]                   mbWdSel, dataSource;
  logic                         vmaUser, ptPublic;
  logic [4:0]                   pfHold;
  logic                         chBufWr, chBufMbSel, dataReverse;
  logic [chBufAdrW-1:0]         chBufAdr;
  logic                         mbParLeft, mbParRight, cbusParLeft, cbusParRight;
  logic                         arParOdd, memParIn, cshParBit, ccwParBit;
  logic                         diagRead;
  logic [mboxPkg::diagSelW-1:0] diagSel;
  logic                         memBusy, coreBusy, chanRead, nxmDataVal, holdEra;
  logic [1:0]                   chBufPar;
  logic                         mbParBitIn, driving;
  logic [0:mboxPkg::ebusW-1]    ebusData;

  int          checkCount;
  int          errCount;
  int unsigned seedVal;

  mboxErrTop #(
    .nxmTimeout (nxmTimeout),
    .chBufAdrW  (chBufAdrW)
  ) uut (.*);

  initial begin
    MBOX = 1'b0;
    forever #4 MBOX = ~MBOX;
  end

  // Last resort against a stuck run
  initial begin
    #50000;
    $display("Simulation did not finish within the time limit");
    $display("Testbench failed");
    $finish;
  end

  task automatic initInputs();
    {memStart, memRdRq, acknPulse, chanCyc, chanToMem} = '0;
    {coreRdInProg, aRToMbSel, nxmErrClr, memError, aChangeComing} = '0;
    {memAdrParErr, errClr, eraSel, ccaRef, vmaUser, ptPublic} = '0;
    {chBufWr, chBufMbSel, dataReverse, mbParLeft, mbParRight} = '0;
    {cbusParLeft, cbusParRight, arParOdd, memParIn, cshParBit, ccwParBit} = '0;
    mbParOdd   = 1'b1;
    physAdr    = '0;
    mbWdSel    = '0;
    dataSource = '0;
    pfHold     = '0;
    chBufAdr   = '0;
    diagRead   = 1'b0;
    diagSel    = '0;
  endtask

  // Drive point just after the rising edge
  task automatic cycle();
    @(posedge MBOX);
    #1;
  endtask

  task automatic sample();
    @(negedge MBOX);
  endtask

  task automatic checkValue(input string testName, input string item,
                            input logic [35:0] expVal, input logic [35:0] actVal);
    checkCount++;
    assert (actVal === expVal)
    else begin
      errCount++;
      $display("[FAIL] %s %s: expected %0h, actual %0h", testName, item, expVal, actVal);
    end
  endtask

  task automatic reportTimeout(input string testName, input string what);
    errCount++;
    $display("%s: gave up waiting for %s", testName, what);
  endtask

  // Start, acknowledge on the second cycle, then drop the start
  task automatic runRequest(input logic [adrW-1:0] adr, input logic rd, input logic parOdd);
    cycle();
    memStart = 1'b1;
    memRdRq  = rd;
    physAdr  = adr;
    cycle();
    acknPulse = 1'b1;
    mbParOdd  = parOdd;
    cycle();
    acknPulse = 1'b0;
    memStart  = 1'b0;
    mbParOdd  = 1'b1;
  endtask

  task automatic testAckRead();
    cycle();
    diagRead = 1'b1;
    diagSel  = 2'd0;
    memStart = 1'b1;
    memRdRq  = 1'b1;
    physAdr  = adrW'($urandom);
    sample();
    checkValue("ackRead", "memBusy", 1, memBusy);
    checkValue("ackRead", "driving", 1, driving);
    cycle();
    sample();
    checkValue("ackRead", "coreBusy", 1, coreBusy);
    // coreBusy, adrParErr, memBusy, nxmAny
    checkValue("ackRead", "group 0", 4'b1010, ebusData[9:12]);
    cycle();
    acknPulse = 1'b1;
    diagSel   = 2'd1;
    cycle();
    acknPulse = 1'b0;
    memStart  = 1'b0;
    sample();
    checkValue("ackRead", "group 1", 4'b0000, ebusData[9:12]);
    checkValue("ackRead", "memBusy idle", 0, memBusy);
  endtask

  task automatic testNxmTimeout();
    int edges;
    int pulses;
    int n;
    cycle();
    diagSel  = 2'd0;
    memStart = 1'b1;
    memRdRq  = 1'b1;
    physAdr  = adrW'($urandom);
    edges    = 0;
    sample();
    while (!ebusData[12] && edges < waitLimit) begin
      cycle();
      edges++;
      sample();
    end
    // First edge sees the start and nxmAny follows nxmTimeout edges later
    if (!ebusData[12])
      reportTimeout("nxmTimeout", "nxmAny");
    else
      checkValue("nxmTimeout", "edges to nxmAny", nxmTimeout + 1, edges);
    pulses = 0;
    n      = 0;
    while (pulses == 0 && n < waitLimit) begin
      cycle();
      n++;
      sample();
      if (nxmDataVal)
        pulses++;
    end
    if (pulses == 0)
      reportTimeout("nxmTimeout", "nxmDataVal");
    cycle();
    memStart = 1'b0;
    diagSel  = 2'd1;
    sample();
    if (nxmDataVal)
      pulses++;
    repeat (3) begin
      cycle();
      sample();
      if (nxmDataVal)
        pulses++;
    end
    checkValue("nxmTimeout", "nxmDataVal pulses", 1, pulses);
    checkValue("nxmTimeout", "nxmErr set", 1, ebusData[9]);
    cycle();
    nxmErrClr = 1'b1;
    cycle();
    nxmErrClr = 1'b0;
    sample();
    checkValue("nxmTimeout", "nxmErr cleared", 0, ebusData[9]);
  endtask

  task automatic testEraFreeze();
    logic [adrW-1:0] adrA;
    logic [adrW-1:0] adrB;
    logic [adrW-1:0] adrC;
    adrA = adrW'($urandom);
    adrB = adrA ^ adrW'($urandom | 1);
    adrC = ~adrA;
    cycle();
    eraSel   = 1'b1;
    diagSel  = 2'd1;
    memStart = 1'b1;
    memRdRq  = 1'b1;
    physAdr  = adrA;
    cycle();
    memError      = 1'b1;
    aChangeComing = 1'b1;
    acknPulse     = 1'b1;
    cycle();
    memError      = 1'b0;
    aChangeComing = 1'b0;
    acknPulse     = 1'b0;
    memStart      = 1'b0;
    cycle();
    memStart = 1'b1;
    physAdr  = adrB;
    cycle();
    acknPulse = 1'b1;
    sample();
    checkValue("eraFreeze", "sbusErr", 1, ebusData[10]);
    checkValue("eraFreeze", "holdEra", 1, holdEra);
    checkValue("eraFreeze", "held address", adrA, ebusData[14:35]);
    cycle();
    acknPulse = 1'b0;
    memStart  = 1'b0;
    errClr    = 1'b1;
    cycle();
    errClr = 1'b0;
    runRequest(adrC, 1'b1, 1'b1);
    sample();
    checkValue("eraFreeze", "address after release", adrC, ebusData[14:35]);
  endtask

  task automatic testEraViews();
    logic [adrW-1:0] adr;
    logic [1:0]      wd;
    logic [1:0]      src;
    logic [4:0]      pf;
    logic            cca;
    logic            vma;
    logic            pub;
    adr = adrW'($urandom);
    wd  = 2'($urandom);
    src = 2'($urandom);
    pf  = 5'($urandom);
    cca = 1'($urandom);
    vma = 1'($urandom);
    pub = 1'($urandom);
    cycle();
    eraSel     = 1'b1;
    mbWdSel    = wd;
    dataSource = src;
    ccaRef     = cca;
    runRequest(adr, 1'b0, 1'b1);
    sample();
    // Without a channel cycle chanRef reads zero and a write sets memWrite
    checkValue("eraViews", "era view", {wd, cca, 1'b0, src, 1'b1, 2'b00}, ebusData[0:8]);
    checkValue("eraViews", "era address", adr, ebusData[14:35]);
    cycle();
    eraSel   = 1'b0;
    vmaUser  = vma;
    pfHold   = pf;
    ptPublic = pub;
    runRequest(adr, 1'b0, 1'b1);
    sample();
    checkValue("eraViews", "pageFail view", {vma, pf, pub, 2'b00}, ebusData[0:8]);
    checkValue("eraViews", "pageFail address", adr, ebusData[14:35]);
  endtask

  task automatic testChanParity();
    logic [1:0]           shadow [0:2**chBufAdrW-1];
    logic [chBufAdrW-1:0] adrList [$];
    logic [chBufAdrW-1:0] adr;
    logic [6:0]           r;
    int                   i;
    // Channel write to memory steers the channel buffer onto the MB
    cycle();
    chanCyc   = 1'b1;
    chanToMem = 1'b1;
    memRdRq   = 1'b0;
    diagSel   = 2'd2;
    for (i = 0; i < 16; i++) begin
      adr = chBufAdrW'($urandom);
      r   = 7'($urandom);
      cycle();
      chBufWr      = 1'b1;
      chBufAdr     = adr;
      chBufMbSel   = r[6] & r[5];
      dataReverse  = r[4];
      cbusParLeft  = r[3];
      cbusParRight = r[2];
      mbParLeft    = r[1];
      mbParRight   = r[0];
      if (chBufMbSel)
        shadow[adr] = {mbParLeft, mbParRight};
      else if (dataReverse)
        shadow[adr] = {cbusParRight, cbusParLeft};
      else
        shadow[adr] = {cbusParLeft, cbusParRight};
      adrList.push_back(adr);
    end
    cycle();
    chBufWr = 1'b0;
    sample();
    checkValue("chanParity", "mbInSel", mboxPkg::mbSelChBuf, ebusData[9:11]);
    checkValue("chanParity", "chanRead on write", 0, chanRead);
    for (i = 0; i < adrList.size(); i++) begin
      cycle();
      chBufAdr = adrList[i];
      cycle();
      sample();
      checkValue("chanParity", "chBufPar", shadow[adrList[i]], chBufPar);
      checkValue("chanParity", "mbParBitIn", ^shadow[adrList[i]], mbParBitIn);
    end
    // A channel cycle toward the EBOX is a channel read
    cycle();
    chanToMem = 1'b0;
    cycle();
    sample();
    checkValue("chanParity", "chanRead", 1, chanRead);
    cycle();
    chanCyc = 1'b0;
  endtask

  task automatic testWriteParity();
    cycle();
    diagSel = 2'd1;
    runRequest(adrW'($urandom), 1'b0, 1'b0);
    sample();
    checkValue("writeParity", "mbParErr on write", 1, ebusData[11]);
    cycle();
    errClr = 1'b1;
    cycle();
    errClr = 1'b0;
    runRequest(adrW'($urandom), 1'b1, 1'b0);
    sample();
    checkValue("writeParity", "mbParErr on read", 0, ebusData[11]);
  endtask

  initial begin
    seedVal    = $urandom(32'h94022330);
    checkCount = 0;
    errCount   = 0;
    arstN      = 1'b0;
    initInputs();
    repeat (3) @(posedge MBOX);
    #1;
    arstN = 1'b1;
    sample();
    checkValue("reset", "holdEra", 1, holdEra);
    checkValue("reset", "driving", 0, driving);
    checkValue("reset", "ebusData", 0, ebusData);
    testAckRead();
    testNxmTimeout();
    testEraFreeze();
    testEraViews();
    testChanParity();
    testWriteParity();
    $display("mboxErrTb: %0d checks, %0d errors", checkCount, errCount);
    if (errCount == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

/* flist.f */
design/mboxPkg.sv
design/coreBusyCtl.sv
design/nxmTimer.sv
design/errorCapture.sv
design/chanParityBuf.sv
design/diagReadMux.sv
design/mboxErrTop.sv
testbench/mboxErrTb.sv
